//--- source/image_proc_pkg.sv
`default_nettype none

package image_proc_pkg;

   // command codes as they appear on comm_cmd
   typedef enum logic [7:0] {
      cmd_param           = 8'd0,
      cmd_send_img        = 8'd1,
      cmd_read_img        = 8'd2,
      cmd_get_status      = 8'd3,
      cmd_apply_add       = 8'd4,
      cmd_apply_threshold = 8'd5,
      cmd_switch_buffers  = 8'd6,
      cmd_apply_invert    = 8'd8,
      cmd_apply_mult      = 8'd12
   } cmd_e;

   typedef enum logic [1:0] {
      op_add,
      op_threshold,
      op_invert,
      op_mult
   } op_e;

   typedef logic [7:0] pixel_t;

   // lo is the pixel at the even byte address
   typedef struct packed {
      pixel_t hi;
      pixel_t lo;
   } mem_word_t;

   typedef struct packed {
      logic [31:0] addr;
      logic        wr_en;
      logic        rd_en;
      mem_word_t   data;
   } mem_req_t;

   typedef struct packed {
      op_e                op;
      logic signed [15:0] add_value;
      logic               clamp;
      pixel_t             threshold;
      pixel_t             replacement;
      logic               upper;
      logic [7:0]         mult_value;
   } op_cfg_t;

   // base is word aligned, count is in pixels
   typedef struct packed {
      logic [31:0] base;
      logic [15:0] count;
      logic [16:0] kind;
   } job_t;

   localparam pixel_t status_bytes [4] = '{8'h11, 8'h22, 8'h33, 8'h44};

endpackage

`default_nettype wire

//--- source/command_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module command_decoder #(
   parameter int mem_bytes = 131072,
   parameter int addr_w    = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [7:0]              comm_cmd,
   input  logic [7:0]              comm_data_in,
   input  logic                    comm_data_in_valid,
   input  logic                    xfer_busy,
   input  logic                    proc_busy,
   output logic                    xfer_start,
   output image_proc_pkg::job_t    xfer,
   output logic                    xfer_dir,
   output logic                    status_start,
   output logic                    proc_start,
   output image_proc_pkg::job_t    proc,
   output image_proc_pkg::op_cfg_t cfg
);
   import image_proc_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_param,
      st_add,
      st_thresh,
      st_mult,
      st_wait,
      st_xfer
   } state_e;

   state_e            state;
   logic [1:0]        cnt;
   logic [15:0]       width;
   logic [15:0]       height;
   logic [15:0]       area;
   logic [addr_w-1:0] input_addr;
   logic [addr_w-1:0] storage_addr;
   cmd_e              pend;
   cmd_e              go_cmd;
   op_cfg_t           cfg_q;
   logic              go;
   logic              fire;

   assign area = width * height;

   // a transfer starts straight from idle so the first image byte is not lost
   always_comb begin
      go = 1'b0;
      go_cmd = pend;
      if (state == st_wait) begin
         go = 1'b1;
      end else if (state == st_idle && comm_data_in_valid &&
                   (comm_cmd == cmd_send_img || comm_cmd == cmd_read_img)) begin
         go = 1'b1;
         go_cmd = cmd_e'(comm_cmd);
      end
      fire = go && !proc_busy && !xfer_busy;
   end

   assign xfer_start = fire && (go_cmd == cmd_send_img || go_cmd == cmd_read_img);
   assign xfer_dir = (go_cmd == cmd_read_img);
   assign proc_start = fire && state == st_wait &&
                       pend inside {cmd_apply_add, cmd_apply_threshold,
                                    cmd_apply_invert, cmd_apply_mult};
   assign status_start = state == st_idle && comm_data_in_valid &&
                         comm_cmd == cmd_get_status;

   assign xfer = '{base: 32'(input_addr), count: area, kind: '0};
   assign proc = '{base: 32'(storage_addr), count: area, kind: '0};
   assign cfg = cfg_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
         cnt <= '0;
         width <= '0;
         height <= '0;
         input_addr <= '0;
         storage_addr <= addr_w'(mem_bytes / 2);
      end else begin
         case (state)
            st_idle: begin
               cnt <= '0;
               if (comm_data_in_valid) begin
                  pend <= cmd_e'(comm_cmd);
                  case (comm_cmd)
                     cmd_param: begin
                        state <= st_param;
                        input_addr <= '0;
                        storage_addr <= addr_w'(mem_bytes / 2);
                     end
                     cmd_send_img, cmd_read_img: begin
                        state <= xfer_start ? st_xfer : st_wait;
                     end
                     cmd_apply_add: begin
                        state <= st_add;
                        cfg_q.op <= op_add;
                     end
                     cmd_apply_threshold: begin
                        state <= st_thresh;
                        cfg_q.op <= op_threshold;
                     end
                     cmd_apply_mult: begin
                        state <= st_mult;
                        cfg_q.op <= op_mult;
                     end
                     cmd_apply_invert: begin
                        state <= st_wait;
                        cfg_q.op <= op_invert;
                     end
                     cmd_switch_buffers: begin
                        input_addr <= storage_addr;
                        storage_addr <= input_addr;
                     end
                     default: state <= st_idle;
                  endcase
               end
            end
            // width then height, low byte first
            st_param: begin
               if (comm_data_in_valid) begin
                  cnt <= cnt + 1'b1;
                  case (cnt)
                     2'd0: width[7:0] <= comm_data_in;
                     2'd1: width[15:8] <= comm_data_in;
                     2'd2: height[7:0] <= comm_data_in;
                     default: begin
                        height[15:8] <= comm_data_in;
                        state <= st_idle;
                     end
                  endcase
               end
            end
            st_add: begin
               if (comm_data_in_valid) begin
                  cnt <= cnt + 1'b1;
                  case (cnt)
                     2'd0: cfg_q.add_value[7:0] <= comm_data_in;
                     2'd1: cfg_q.add_value[15:8] <= comm_data_in;
                     default: begin
                        cfg_q.clamp <= comm_data_in[0];
                        state <= st_wait;
                     end
                  endcase
               end
            end
            st_thresh: begin
               if (comm_data_in_valid) begin
                  cnt <= cnt + 1'b1;
                  case (cnt)
                     2'd0: cfg_q.threshold <= comm_data_in;
                     2'd1: cfg_q.replacement <= comm_data_in;
                     default: begin
                        cfg_q.upper <= comm_data_in[0];
                        state <= st_wait;
                     end
                  endcase
               end
            end
            st_mult: begin
               if (comm_data_in_valid) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == 2'd0) begin
                     cfg_q.mult_value <= comm_data_in;
                  end else begin
                     cfg_q.clamp <= comm_data_in[0];
                     state <= st_wait;
                  end
               end
            end
            // held here until both memory users are idle
            st_wait: begin
               if (fire) begin
                  state <= xfer_start ? st_xfer : st_idle;
               end
            end
            // image bytes belong to the streamer until it drops busy
            st_xfer: begin
               if (!xfer_busy) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) !(xfer_start && proc_start));

endmodule

`default_nettype wire

//--- source/pixel_engine.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_engine (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      proc_start,
   input  image_proc_pkg::job_t      proc,
   input  image_proc_pkg::op_cfg_t   cfg,
   input  image_proc_pkg::mem_word_t data_read,
   input  logic                      data_read_valid,
   output image_proc_pkg::mem_req_t  eng_req,
   output logic                      proc_busy
);
   import image_proc_pkg::*;

   typedef enum logic [1:0] {
      e_idle,
      e_read,
      e_wait,
      e_write
   } state_e;

   state_e      state;
   logic [31:0] addr_q;
   logic [14:0] words_left;
   op_cfg_t     cfg_q;
   mem_word_t   result;

   function automatic pixel_t apply_op(input pixel_t p, input op_cfg_t c);
      logic signed [15:0] sum;
      logic [15:0]        prod;
      pixel_t             res;
      sum = $signed({8'h00, p}) + c.add_value;
      // mult_value carries 4 fractional bits
      prod = {8'h00, c.mult_value} * {8'h00, p};
      case (c.op)
         op_add: begin
            if (c.clamp && sum < 0) begin
               res = 8'h00;
            end else if (c.clamp && sum > 255) begin
               res = 8'hff;
            end else begin
               res = sum[7:0];
            end
         end
         op_threshold: begin
            if (c.upper ? (p >= c.threshold) : (p <= c.threshold)) begin
               res = c.replacement;
            end else begin
               res = p;
            end
         end
         op_invert: res = 8'hff - p;
         default: begin
            if (c.clamp && prod[15:12] != 4'h0) begin
               res = 8'hff;
            end else begin
               res = prod[11:4];
            end
         end
      endcase
      return res;
   endfunction

   // one word in flight: read, wait, write back to the same address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= e_idle;
      end else begin
         case (state)
            e_idle: begin
               if (proc_start && proc.count[15:1] != '0) begin
                  state <= e_read;
               end
            end
            e_read: state <= e_wait;
            e_wait: begin
               if (data_read_valid) begin
                  state <= e_write;
               end
            end
            default: state <= (words_left == 15'd1) ? e_idle : e_read;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == e_idle && proc_start) begin
         addr_q <= proc.base;
         words_left <= proc.count[15:1];
         cfg_q <= cfg;
      end
      if (state == e_wait && data_read_valid) begin
         result.lo <= apply_op(data_read.lo, cfg_q);
         result.hi <= apply_op(data_read.hi, cfg_q);
      end
      if (state == e_write) begin
         addr_q <= addr_q + 32'd2;
         words_left <= words_left - 1'b1;
      end
   end

   always_comb begin
      eng_req = '0;
      eng_req.addr = addr_q;
      eng_req.data = result;
      eng_req.rd_en = (state == e_read);
      eng_req.wr_en = (state == e_write);
   end

   assign proc_busy = (state != e_idle);

   // a new job only arrives while the engine is idle
   assert property (@(posedge clk) disable iff (!rst_n) proc_start |-> state == e_idle);

endmodule

`default_nettype wire

//--- source/image_streamer.sv
`timescale 1ns/10ps
`default_nettype none

module image_streamer (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      xfer_start,
   input  image_proc_pkg::job_t      xfer,
   input  logic                      xfer_dir,
   input  logic                      status_start,
   input  logic [7:0]                comm_data_in,
   input  logic                      comm_data_in_valid,
   input  logic                      comm_data_out_free,
   input  image_proc_pkg::mem_req_t  eng_req,
   input  logic                      proc_busy,
   input  image_proc_pkg::mem_word_t data_read,
   input  logic                      data_read_valid,
   output image_proc_pkg::mem_req_t  mem,
   output image_proc_pkg::pixel_t    comm_data_out,
   output logic                      comm_data_out_valid,
   output logic                      xfer_busy
);
   import image_proc_pkg::*;

   typedef enum logic [2:0] {
      s_idle,
      s_write,
      s_rd_req,
      s_rd_wait,
      s_rd_lo,
      s_rd_hi,
      s_status
   } state_e;

   state_e      state;
   logic [31:0] addr_q;
   logic [15:0] left;
   logic        hi_next;
   logic [1:0]  st_cnt;
   pixel_t      lo_q;
   mem_word_t   word_q;
   mem_req_t    own_req;
   logic        own_active;
   logic        out_now;
   pixel_t      out_byte;

   // the engine owns the port whenever no image transfer runs
   always_comb begin
      own_req = '0;
      own_req.addr = addr_q;
      own_req.data = '{hi: comm_data_in, lo: lo_q};
      own_req.wr_en = (state == s_write) && comm_data_in_valid && hi_next;
      own_req.rd_en = (state == s_rd_req);
      own_active = state inside {s_write, s_rd_req, s_rd_wait, s_rd_lo, s_rd_hi};
      mem = own_active ? own_req : eng_req;
   end

   always_comb begin
      out_now = comm_data_out_free && state inside {s_rd_lo, s_rd_hi, s_status};
      case (state)
         s_rd_lo: out_byte = word_q.lo;
         s_rd_hi: out_byte = word_q.hi;
         default: begin
            out_byte = status_bytes[st_cnt];
            // first status byte reports the engine
            if (st_cnt == 2'd0) begin
               out_byte[0] = proc_busy;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= s_idle;
         comm_data_out_valid <= 1'b0;
         hi_next <= 1'b0;
         st_cnt <= '0;
      end else begin
         comm_data_out_valid <= out_now;
         case (state)
            s_idle: begin
               hi_next <= 1'b0;
               st_cnt <= '0;
               if (xfer_start && xfer.count != '0) begin
                  state <= xfer_dir ? s_rd_req : s_write;
               end else if (status_start) begin
                  state <= s_status;
               end
            end
            s_write: begin
               if (comm_data_in_valid) begin
                  hi_next <= !hi_next;
                  if (left == 16'd1) begin
                     state <= s_idle;
                  end
               end
            end
            s_rd_req: state <= s_rd_wait;
            s_rd_wait: begin
               if (data_read_valid) begin
                  state <= s_rd_lo;
               end
            end
            s_rd_lo: begin
               if (comm_data_out_free) begin
                  state <= s_rd_hi;
               end
            end
            s_rd_hi: begin
               if (comm_data_out_free) begin
                  state <= (left <= 16'd2) ? s_idle : s_rd_req;
               end
            end
            default: begin
               if (comm_data_out_free) begin
                  st_cnt <= st_cnt + 1'b1;
                  if (st_cnt == 2'd3) begin
                     state <= s_idle;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (out_now) begin
         comm_data_out <= out_byte;
      end
      if (state == s_idle) begin
         addr_q <= xfer.base;
         left <= xfer.count;
      end
      // even byte waits in lo_q, odd byte completes the word write
      if (state == s_write && comm_data_in_valid) begin
         left <= left - 1'b1;
         if (hi_next) begin
            addr_q <= addr_q + 32'd2;
         end else begin
            lo_q <= comm_data_in;
         end
      end
      if (state == s_rd_wait && data_read_valid) begin
         word_q <= data_read;
      end
      if (state == s_rd_hi && comm_data_out_free) begin
         addr_q <= addr_q + 32'd2;
         left <= left - 16'd2;
      end
   end

   assign xfer_busy = (state != s_idle);

   // engine traffic never shows up while a transfer holds the port
   assert property (@(posedge clk) disable iff (!rst_n)
      own_active |-> !(eng_req.wr_en || eng_req.rd_en));

endmodule

`default_nettype wire

//--- source/image_proc.sv
`timescale 1ns/10ps
`default_nettype none

module image_proc #(
   parameter int mem_bytes = 131072,
   parameter int addr_w    = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [7:0]               comm_cmd,
   input  logic [7:0]               comm_data_in,
   input  logic                     comm_data_in_valid,
   output image_proc_pkg::pixel_t   comm_data_out,
   output logic                     comm_data_out_valid,
   input  logic                     comm_data_out_free,
   output image_proc_pkg::mem_req_t mem,
   input  image_proc_pkg::mem_word_t data_read,
   input  logic                     data_read_valid
);
   import image_proc_pkg::*;

   logic     xfer_start;
   job_t     xfer;
   logic     xfer_dir;
   logic     xfer_busy;
   logic     status_start;
   logic     proc_start;
   job_t     proc;
   op_cfg_t  cfg;
   logic     proc_busy;
   mem_req_t eng_req;

   command_decoder #(
      .mem_bytes (mem_bytes),
      .addr_w    (addr_w)
   ) u_decoder (
      .clk                (clk),
      .rst_n              (rst_n),
      .comm_cmd           (comm_cmd),
      .comm_data_in       (comm_data_in),
      .comm_data_in_valid (comm_data_in_valid),
      .xfer_busy          (xfer_busy),
      .proc_busy          (proc_busy),
      .xfer_start         (xfer_start),
      .xfer               (xfer),
      .xfer_dir           (xfer_dir),
      .status_start       (status_start),
      .proc_start         (proc_start),
      .proc               (proc),
      .cfg                (cfg)
   );

   pixel_engine u_engine (
      .clk             (clk),
      .rst_n           (rst_n),
      .proc_start      (proc_start),
      .proc            (proc),
      .cfg             (cfg),
      .data_read       (data_read),
      .data_read_valid (data_read_valid),
      .eng_req         (eng_req),
      .proc_busy       (proc_busy)
   );

   image_streamer u_streamer (
      .clk                 (clk),
      .rst_n               (rst_n),
      .xfer_start          (xfer_start),
      .xfer                (xfer),
      .xfer_dir            (xfer_dir),
      .status_start        (status_start),
      .comm_data_in        (comm_data_in),
      .comm_data_in_valid  (comm_data_in_valid),
      .comm_data_out_free  (comm_data_out_free),
      .eng_req             (eng_req),
      .proc_busy           (proc_busy),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid),
      .mem                 (mem),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid),
      .xfer_busy           (xfer_busy)
   );

endmodule

`default_nettype wire

//--- dv/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model #(
   parameter int mem_bytes = 131072
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  image_proc_pkg::mem_req_t  req,
   output image_proc_pkg::mem_word_t data_read,
   output logic                      data_read_valid
);
   import image_proc_pkg::*;

   localparam int words = mem_bytes / 2;
   localparam int idx_w = $clog2(words);

   mem_word_t        store [words];
   logic [idx_w-1:0] rd_idx;
   logic [1:0]       wait_cnt;
   logic [1:0]       lat_sel;
   logic             pending;

   // fill pattern mixes every address bit
   initial begin
      for (int i = 0; i < words; i++) begin
         store[i] = 16'(i * 40503) ^ 16'(i >> 3);
      end
   end

   // read latency cycles through 1, 2 and 3
   always @(posedge clk) begin
      data_read_valid <= 1'b0;
      if (!rst_n) begin
         pending <= 1'b0;
         lat_sel <= '0;
         wait_cnt <= '0;
         data_read <= '0;
      end else begin
         if (req.wr_en) begin
            store[req.addr[idx_w:1]] <= req.data;
         end
         if (req.rd_en) begin
            lat_sel <= (lat_sel == 2'd2) ? 2'd0 : lat_sel + 1'b1;
            rd_idx <= req.addr[idx_w:1];
            if (lat_sel == 2'd0) begin
               data_read <= store[req.addr[idx_w:1]];
               data_read_valid <= 1'b1;
            end else begin
               pending <= 1'b1;
               wait_cnt <= lat_sel;
            end
         end else if (pending) begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == 2'd1) begin
               pending <= 1'b0;
               data_read <= store[rd_idx];
               data_read_valid <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/image_proc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module image_proc_tb;
   import image_proc_pkg::*;

   localparam int mem_bytes = 131072;
   localparam int width = 8;
   localparam int height = 4;
   localparam int npix = width * height;
   // whole sequence needs about 5000 cycles, limit leaves room for slow free toggling
   localparam int timeout_cycles = 20000;
   localparam int byte_wait_limit = 500;
   localparam pixel_t status_tail [3] = '{8'h22, 8'h33, 8'h44};
   // corner values that exercise clamping and wraparound
   localparam pixel_t corner [4] = '{8'h00, 8'hff, 8'h7f, 8'h80};

   logic      clk;
   logic      rst_n;
   logic [7:0] comm_cmd;
   logic [7:0] comm_data_in;
   logic      comm_data_in_valid;
   pixel_t    comm_data_out;
   logic      comm_data_out_valid;
   logic      comm_data_out_free;
   mem_req_t  mem;
   mem_word_t data_read;
   logic      data_read_valid;

   int        cycles;
   logic      free_random;
   pixel_t    rx_q [$];
   // model[0] sits at byte address 0, model[1] at mem_bytes/2
   pixel_t    model [2][npix];
   int        in_sel;

   image_proc #(
      .mem_bytes (mem_bytes),
      .addr_w    (32)
   ) DUT (
      .clk                 (clk),
      .rst_n               (rst_n),
      .comm_cmd            (comm_cmd),
      .comm_data_in        (comm_data_in),
      .comm_data_in_valid  (comm_data_in_valid),
      .comm_data_out       (comm_data_out),
      .comm_data_out_valid (comm_data_out_valid),
      .comm_data_out_free  (comm_data_out_free),
      .mem                 (mem),
      .data_read           (data_read),
      .data_read_valid     (data_read_valid)
   );

   mem_model #(
      .mem_bytes (mem_bytes)
   ) u_mem (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (mem),
      .data_read       (data_read),
      .data_read_valid (data_read_valid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: run still busy after %0d cycles", cycles);
         stop_with_fail();
      end
   end

   // output bytes are registered, so sample just after the edge
   always @(posedge clk) begin
      #1;
      if (rst_n && comm_data_out_valid) begin
         rx_q.push_back(comm_data_out);
      end
   end

   task automatic stop_with_fail();
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first error");
   endtask

   // inputs change 2 ns after the rising edge
   task automatic tick(input int n = 1);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic check_byte(input string name, input pixel_t got, input pixel_t exp);
      assert (got === exp) else begin
         $display("mismatch at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic send_byte(input logic [7:0] cmd, input logic [7:0] data);
      comm_cmd = cmd;
      comm_data_in = data;
      comm_data_in_valid = 1'b1;
      tick();
      comm_data_in_valid = 1'b0;
   endtask

   task automatic get_byte(output pixel_t b);
      int waited;
      waited = 0;
      while (rx_q.size() == 0) begin
         assert (waited < byte_wait_limit) else begin
            $display("no output byte arrived within %0d cycles", byte_wait_limit);
            stop_with_fail();
         end
         comm_data_out_free = free_random ? 1'($urandom % 2) : 1'b1;
         tick();
         waited++;
      end
      b = rx_q.pop_front();
   endtask

   task automatic expect_byte(input string name, input pixel_t exp);
      pixel_t b;
      get_byte(b);
      check_byte(name, b, exp);
   endtask

   task automatic read_status(output pixel_t b0);
      send_byte(cmd_get_status, 8'h00);
      get_byte(b0);
      for (int i = 0; i < 3; i++) begin
         expect_byte($sformatf("status byte %0d", i + 1), status_tail[i]);
      end
   endtask

   task automatic check_status(input pixel_t exp0);
      pixel_t b0;
      read_status(b0);
      check_byte("status byte 0", b0, exp0);
   endtask

   // poll until the busy bit clears
   task automatic wait_proc_done();
      pixel_t b0;
      b0 = 8'h11;
      while (b0[0]) begin
         read_status(b0);
         assert (b0 inside {8'h10, 8'h11}) else begin
            $display("mismatch at %0t ns: status byte 0 = 0x%02h, expected 0x10 or 0x11",
                     $time, b0);
            stop_with_fail();
         end
      end
   endtask

   function automatic pixel_t expected_pixel(input cmd_e c, input pixel_t prm [3],
                                             input pixel_t p);
      int v;
      int r;
      case (c)
         cmd_apply_add: begin
            v = {prm[1], prm[0]};
            if (v > 32767) begin
               v -= 65536;
            end
            r = int'(p) + v;
            if (prm[2][0]) begin
               r = (r < 0) ? 0 : ((r > 255) ? 255 : r);
            end
         end
         cmd_apply_threshold: begin
            r = p;
            if (prm[2][0] ? (p >= prm[0]) : (p <= prm[0])) begin
               r = prm[1];
            end
         end
         // multiplier has 4 fractional bits
         cmd_apply_mult: begin
            r = (int'(prm[0]) * int'(p)) / 16;
            if (prm[1][0] && r > 255) begin
               r = 255;
            end
         end
         default: r = 255 - int'(p);
      endcase
      return pixel_t'(r);
   endfunction

   task automatic set_size(input int w, input int h);
      send_byte(cmd_param, 8'h00);
      send_byte(8'h00, w[7:0]);
      send_byte(8'h00, w[15:8]);
      send_byte(8'h00, h[7:0]);
      send_byte(8'h00, h[15:8]);
      tick(2);
      in_sel = 0;
   endtask

   task automatic switch_buffers();
      send_byte(cmd_switch_buffers, 8'h00);
      tick();
      in_sel = 1 - in_sel;
   endtask

   task automatic load_image();
      for (int i = 0; i < npix; i++) begin
         model[in_sel][i] = (i < 4) ? corner[i] : pixel_t'($urandom);
      end
      send_byte(cmd_send_img, 8'h00);
      for (int i = 0; i < npix; i++) begin
         send_byte(8'h00, model[in_sel][i]);
      end
      tick(3);
   endtask

   task automatic read_check(input string name);
      free_random = 1'b1;
      send_byte(cmd_read_img, 8'h00);
      for (int i = 0; i < npix; i++) begin
         expect_byte($sformatf("%s pixel %0d", name, i), model[in_sel][i]);
      end
      free_random = 1'b0;
      comm_data_out_free = 1'b1;
      tick(6);
      assert (rx_q.size() == 0) else begin
         $display("read of %s returned %0d extra bytes", name, rx_q.size());
         stop_with_fail();
      end
   endtask

   // the job works on the storage buffer, the one that is not the input
   task automatic start_job(input cmd_e c, input pixel_t p0, input pixel_t p1,
                            input pixel_t p2, input int nparams);
      pixel_t prm [3];
      int     st;
      prm = '{p0, p1, p2};
      st = 1 - in_sel;
      send_byte(c, 8'h00);
      for (int i = 0; i < nparams; i++) begin
         send_byte(8'h00, prm[i]);
      end
      for (int i = 0; i < npix; i++) begin
         model[st][i] = expected_pixel(c, prm, model[st][i]);
      end
      tick(2);
   endtask

   task automatic run_job(input string name, input cmd_e c, input pixel_t p0,
                          input pixel_t p1, input pixel_t p2, input int nparams);
      switch_buffers();
      start_job(c, p0, p1, p2, nparams);
      wait_proc_done();
      switch_buffers();
      read_check(name);
   endtask

   task automatic test_status_after_reset();
      check_status(8'h10);
   endtask

   task automatic test_load_read();
      set_size(width, height);
      load_image();
      read_check("readback");
   endtask

   task automatic test_add();
      load_image();
      run_job("add -40 clamped", cmd_apply_add, 8'hd8, 8'hff, 8'h01, 3);
      run_job("add +100 wrapped", cmd_apply_add, 8'h64, 8'h00, 8'h00, 3);
   endtask

   task automatic test_threshold_invert();
      load_image();
      run_job("threshold upper", cmd_apply_threshold, 8'h80, 8'h00, 8'h01, 3);
      run_job("threshold lower", cmd_apply_threshold, 8'h30, 8'hee, 8'h00, 3);
      run_job("invert", cmd_apply_invert, 8'h00, 8'h00, 8'h00, 0);
   endtask

   task automatic test_mult();
      load_image();
      run_job("mult 1.5 clamped", cmd_apply_mult, 8'h18, 8'h01, 8'h00, 2);
      run_job("mult 1.5 truncated", cmd_apply_mult, 8'h18, 8'h00, 8'h00, 2);
   endtask

   // read is issued while the engine still runs and must wait for it
   task automatic test_busy();
      load_image();
      switch_buffers();
      start_job(cmd_apply_invert, 8'h00, 8'h00, 8'h00, 0);
      check_status(8'h11);
      switch_buffers();
      read_check("read during job");
      check_status(8'h10);
   endtask

   initial begin
      void'($urandom(32'h88b1527c));
      rst_n = 1'b0;
      comm_cmd = '0;
      comm_data_in = '0;
      comm_data_in_valid = 1'b0;
      comm_data_out_free = 1'b1;
      free_random = 1'b0;
      in_sel = 0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      tick(2);
      test_status_after_reset();
      test_load_read();
      test_add();
      test_threshold_invert();
      test_mult();
      test_busy();
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- image_proc.f
source/image_proc_pkg.sv
source/command_decoder.sv
source/pixel_engine.sv
source/image_streamer.sv
source/image_proc.sv
dv/mem_model.sv
dv/image_proc_tb.sv
